//--- dram_geom_pkg.sv
package dram_geom_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address geometry of one channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int BANK_BITS = 2;               // bank select bits
    localparam int ROW_BITS  = 8;               // row address bits
    localparam int COL_BITS  = 6;               // column address bits

    // one open-row register per bank in the scheduler
    localparam int NUM_BANKS = 1 << BANK_BITS;  // 4 banks

endpackage

//--- req_fmt_pkg.sv
package req_fmt_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request word layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // msb to lsb the word is bank, row, column, type, data
    // bank, row and column sit next to each other so the scheduler
    // can compare a whole address as one slice

    localparam int DATA_BITS = 16;              // write payload
    localparam int TYPE_BITS = 1;               // read or write flag

    // field positions, lsb of each field
    localparam int DATA_POS  = 0;
    localparam int TYPE_POS  = DATA_POS + DATA_BITS;                // bit 16
    localparam int COL_POS   = TYPE_POS + TYPE_BITS;                // bit 17
    localparam int ROW_POS   = COL_POS + dram_geom_pkg::COL_BITS;   // bit 23
    localparam int BANK_POS  = ROW_POS + dram_geom_pkg::ROW_BITS;   // bit 31

    // total width, 33 bits
    localparam int REQ_BITS  = BANK_POS + dram_geom_pkg::BANK_BITS;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // type encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic REQ_READ  = 1'b0;          // read access
    localparam logic REQ_WRITE = 1'b1;          // write access

endpackage

//--- generic_fifo.sv
module generic_fifo #(
    parameter int REQ_W      = req_fmt_pkg::REQ_BITS,  // payload width
    parameter int FIFO_DEPTH = 4                       // number of slots
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [REQ_W-1:0] data_i,    // write side payload
    input  logic             valid_i,   // write side request
    output logic             grant_o,   // high while not full
    output logic [REQ_W-1:0] data_o,    // head of queue
    output logic             valid_o,   // head present
    input  logic             grant_i    // read side takes the head
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage and pointers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [REQ_W-1:0] mem [FIFO_DEPTH];   // circular buffer
    logic [PTR_W-1:0] wr_ptr;             // next free slot
    logic [PTR_W-1:0] rd_ptr;             // current head
    logic [CNT_W-1:0] count;              // occupancy
    logic             push;
    logic             pop;

    assign grant_o = (count != CNT_W'(FIFO_DEPTH));  // full drops grant
    assign valid_o = (count != '0);
    assign data_o  = mem[rd_ptr];                    // head straight from buffer

    assign push = valid_i && grant_o;   // accepted this edge
    assign pop  = valid_o && grant_i;   // head leaves this edge

    // pointers wrap at depth, so any depth works
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;   // push only
                2'b01:   count <= count - 1'b1;   // pop only
                default: count <= count;          // both or neither
            endcase
        end
    end

    // payload write
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule

//--- open_row_table.sv
module open_row_table #(
    parameter int WINDOW_DEPTH = 4   // one lookup per window slot
) (
    input  logic                                                    clk,
    input  logic                                                    reset_i,
    input  logic [WINDOW_DEPTH-1:0][dram_geom_pkg::BANK_BITS-1:0]   lookup_bank_i,
    input  logic [WINDOW_DEPTH-1:0][dram_geom_pkg::ROW_BITS-1:0]    lookup_row_i,
    output logic [WINDOW_DEPTH-1:0]                                 hit_o,
    input  logic                                                    upd_en_i,
    input  logic [dram_geom_pkg::BANK_BITS-1:0]                     upd_bank_i,
    input  logic [dram_geom_pkg::ROW_BITS-1:0]                      upd_row_i
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // open row per bank
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [dram_geom_pkg::ROW_BITS-1:0]  open_row [dram_geom_pkg::NUM_BANKS];
    logic [dram_geom_pkg::NUM_BANKS-1:0] row_vld;   // bank has a row open

    always_ff @(posedge clk) begin
        if (reset_i) begin
            row_vld <= '0;                          // all banks closed
            for (int b = 0; b < dram_geom_pkg::NUM_BANKS; b++) begin
                open_row[b] <= '0;
            end
        end else if (upd_en_i) begin
            open_row[upd_bank_i] <= upd_row_i;      // issued row stays open
            row_vld[upd_bank_i]  <= 1'b1;
        end
    end

    // parallel hit query, one per slot
    always_comb begin
        for (int i = 0; i < WINDOW_DEPTH; i++) begin
            hit_o[i] = row_vld[lookup_bank_i[i]] &&
                       (open_row[lookup_bank_i[i]] == lookup_row_i[i]);
        end
    end

endmodule

//--- bank_scheduler.sv
module bank_scheduler #(
    parameter int WINDOW_DEPTH = 4   // reorder window size
) (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              valid_i,          // fifo head present
    input  logic [req_fmt_pkg::REQ_BITS-1:0]  data_i,           // fifo head
    output logic                              grant_o,          // window takes the head
    input  logic                              issue_ready_i,    // memory side ready
    output logic                              issue_valid_o,
    output logic [req_fmt_pkg::REQ_BITS-1:0]  issue_data_o,
    output logic                              issue_row_hit_o
);

    localparam int IDX_W = (WINDOW_DEPTH > 1) ? $clog2(WINDOW_DEPTH) : 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reorder window
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // slot 0 is the oldest entry, valid slots are always packed at the low end

    logic [req_fmt_pkg::REQ_BITS-1:0] win_data [WINDOW_DEPTH];   // entry payloads
    logic [WINDOW_DEPTH-1:0]          win_vld;                   // slot holds a request
    logic [req_fmt_pkg::REQ_BITS-1:0] nxt_data [WINDOW_DEPTH];   // after shift and append
    logic [WINDOW_DEPTH-1:0]          nxt_vld;
    logic [WINDOW_DEPTH-1:0]          shf_vld;                   // after removal only
    logic                             slot_found;                // first free slot seen

    // per entry fields and selection flags
    logic [WINDOW_DEPTH-1:0][dram_geom_pkg::BANK_BITS-1:0] win_bank;
    logic [WINDOW_DEPTH-1:0][dram_geom_pkg::ROW_BITS-1:0]  win_row;
    logic [WINDOW_DEPTH-1:0] win_hit;    // row hit from table
    logic [WINDOW_DEPTH-1:0] win_haz;    // older same address present
    logic [WINDOW_DEPTH-1:0] win_elig;   // may be picked

    logic             pick_en;     // load output register this edge
    logic [IDX_W-1:0] pick_idx;    // winning slot
    logic             take;        // fifo head enters window

    // output register
    logic                             out_vld;
    logic [req_fmt_pkg::REQ_BITS-1:0] out_data;
    logic                             out_hit;

    // field slices of every slot
    always_comb begin
        for (int i = 0; i < WINDOW_DEPTH; i++) begin
            win_bank[i] = win_data[i][req_fmt_pkg::BANK_POS +: dram_geom_pkg::BANK_BITS];
            win_row[i]  = win_data[i][req_fmt_pkg::ROW_POS +: dram_geom_pkg::ROW_BITS];
        end
    end

    open_row_table #(
        .WINDOW_DEPTH (WINDOW_DEPTH)
    ) rows (
        .clk           (clk),
        .reset_i       (reset_i),
        .lookup_bank_i (win_bank),
        .lookup_row_i  (win_row),
        .hit_o         (win_hit),
        .upd_en_i      (pick_en),              // picked row becomes open
        .upd_bank_i    (win_bank[pick_idx]),
        .upd_row_i     (win_row[pick_idx])
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hazard and selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // bank, row and column are contiguous from COL_POS up to the msb
    always_comb begin
        for (int i = 0; i < WINDOW_DEPTH; i++) begin
            win_haz[i] = 1'b0;
            for (int j = 0; j < i; j++) begin   // older slots only
                if (win_vld[j] &&
                    (win_data[j][req_fmt_pkg::REQ_BITS-1:req_fmt_pkg::COL_POS] ==
                     win_data[i][req_fmt_pkg::REQ_BITS-1:req_fmt_pkg::COL_POS])) begin
                    win_haz[i] = 1'b1;
                end
            end
            win_elig[i] = win_vld[i] && !win_haz[i];
        end
    end

    // scan young to old so the oldest hit wins
    always_comb begin
        pick_idx = '0;             // no hit falls back to slot 0, never blocked
        for (int i = WINDOW_DEPTH - 1; i >= 0; i--) begin
            if (win_elig[i] && win_hit[i]) begin
                pick_idx = IDX_W'(i);
            end
        end
    end

    // pick when the output register is empty or drains this edge
    assign pick_en = win_vld[0] && (!out_vld || issue_ready_i);

    // room now, or a slot frees up in the same edge
    assign grant_o = !win_vld[WINDOW_DEPTH-1] || pick_en;
    assign take    = valid_i && grant_o;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compaction and append
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int i = 0; i < WINDOW_DEPTH; i++) begin
            if (pick_en && (i >= pick_idx)) begin        // close the gap
                if (i < WINDOW_DEPTH - 1) begin
                    nxt_data[i] = win_data[(i < WINDOW_DEPTH - 1) ? i + 1 : i];
                    shf_vld[i]  = win_vld[(i < WINDOW_DEPTH - 1) ? i + 1 : i];
                end else begin
                    nxt_data[i] = win_data[i];           // top slot empties
                    shf_vld[i]  = 1'b0;
                end
            end else begin
                nxt_data[i] = win_data[i];
                shf_vld[i]  = win_vld[i];
            end
        end

        // new entry goes behind the youngest survivor
        nxt_vld    = shf_vld;
        slot_found = 1'b0;
        for (int i = 0; i < WINDOW_DEPTH; i++) begin
            if (!shf_vld[i] && !slot_found) begin
                slot_found = 1'b1;
                if (take) begin
                    nxt_data[i] = data_i;
                    nxt_vld[i]  = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            win_vld <= '0;          // window empty
        end else begin
            win_vld <= nxt_vld;
        end
    end

    always_ff @(posedge clk) begin
        win_data <= nxt_data;       // payload follows the valid bits
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_vld <= 1'b0;
        end else if (pick_en) begin
            out_vld <= 1'b1;        // refilled behind or without a handshake
        end else if (issue_ready_i) begin
            out_vld <= 1'b0;        // drained with nothing to follow
        end
    end

    // held while ready is low
    always_ff @(posedge clk) begin
        if (pick_en) begin
            out_data <= win_data[pick_idx];
            out_hit  <= win_hit[pick_idx];   // hit against rows before this update
        end
    end

    assign issue_valid_o   = out_vld;
    assign issue_data_o    = out_data;
    assign issue_row_hit_o = out_hit;

endmodule

//--- bank_sched_top.sv
module bank_sched_top #(
    parameter int FIFO_DEPTH   = 4,   // request queue slots
    parameter int WINDOW_DEPTH = 4    // scheduler reorder window
) (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              req_valid_i,
    input  logic [req_fmt_pkg::REQ_BITS-1:0]  req_data_i,
    output logic                              req_grant_o,
    input  logic                              issue_ready_i,
    output logic                              issue_valid_o,
    output logic [req_fmt_pkg::REQ_BITS-1:0]  issue_data_o,
    output logic                              issue_row_hit_o
);

    // fifo to scheduler
    logic [req_fmt_pkg::REQ_BITS-1:0] fifo_data;    // queue head
    logic                             fifo_valid;   // head present
    logic                             sched_grant;  // scheduler takes head

    generic_fifo #(
        .REQ_W      (req_fmt_pkg::REQ_BITS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) req_fifo (
        .clk     (clk),
        .reset_i (reset_i),
        .data_i  (req_data_i),
        .valid_i (req_valid_i),
        .grant_o (req_grant_o),
        .data_o  (fifo_data),
        .valid_o (fifo_valid),
        .grant_i (sched_grant)
    );

    bank_scheduler #(
        .WINDOW_DEPTH (WINDOW_DEPTH)
    ) sched (
        .clk             (clk),
        .reset_i         (reset_i),
        .valid_i         (fifo_valid),
        .data_i          (fifo_data),
        .grant_o         (sched_grant),
        .issue_ready_i   (issue_ready_i),
        .issue_valid_o   (issue_valid_o),
        .issue_data_o    (issue_data_o),
        .issue_row_hit_o (issue_row_hit_o)
    );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 10,    // clock period
    parameter int RESET_CYCLES = 3      // edges with reset high
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;                          // in reset from the start
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;                         // drops right after the last reset edge
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

//--- bank_sched_checker.sv
module bank_sched_checker #(
    parameter int FIFO_DEPTH   = 4,
    parameter int WINDOW_DEPTH = 4
) (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             req_valid_i,
    input  logic [req_fmt_pkg::REQ_BITS-1:0] req_data_i,
    input  logic [1:0]                       exp_hit_i,      // 0, 1, or 2 for any
    input  logic                             req_grant_i,
    input  logic                             issue_ready_i,
    input  logic                             issue_valid_i,
    input  logic [req_fmt_pkg::REQ_BITS-1:0] issue_data_i,
    input  logic                             issue_row_hit_i,
    input  logic                             test_done_i,
    input  int                               test_id_i,
    output logic                             idle_o,         // model fully drained
    output int                               accepted_o,
    output int                               issued_o,
    output int                               errors_o,
    output int                               tests_passed_o,
    output int                               tests_failed_o
);

    localparam int ENT_W = req_fmt_pkg::REQ_BITS + 2;   // expected hit code on top

    logic [ENT_W-1:0]                    m_fifo [$];    // model request queue
    logic [ENT_W-1:0]                    m_win [$];     // model window, index 0 oldest
    logic [ENT_W-1:0]                    m_out;         // model output register
    logic                                m_out_vld;
    logic                                m_out_hit;
    logic [dram_geom_pkg::ROW_BITS-1:0]  m_row [dram_geom_pkg::NUM_BANKS];
    logic [dram_geom_pkg::NUM_BANKS-1:0] m_row_vld;     // bank has an open row
    int                                  err_mark;      // errors before this test

    function automatic logic [dram_geom_pkg::BANK_BITS-1:0] bank_of(input logic [ENT_W-1:0] e);
        return e[req_fmt_pkg::BANK_POS +: dram_geom_pkg::BANK_BITS];
    endfunction

    function automatic logic [dram_geom_pkg::ROW_BITS-1:0] row_of(input logic [ENT_W-1:0] e);
        return e[req_fmt_pkg::ROW_POS +: dram_geom_pkg::ROW_BITS];
    endfunction

    function automatic logic [dram_geom_pkg::COL_BITS-1:0] col_of(input logic [ENT_W-1:0] e);
        return e[req_fmt_pkg::COL_POS +: dram_geom_pkg::COL_BITS];
    endfunction

    function automatic logic same_addr(input logic [ENT_W-1:0] a, input logic [ENT_W-1:0] b);
        return (bank_of(a) == bank_of(b)) && (row_of(a) == row_of(b)) && (col_of(a) == col_of(b));
    endfunction

    function automatic logic open_hit(input logic [ENT_W-1:0] e);
        return m_row_vld[bank_of(e)] && (m_row[bank_of(e)] == row_of(e));
    endfunction

    // oldest unblocked row hit, else the oldest entry
    function automatic int choose_entry();
        int   pick;
        logic blocked;
        pick = -1;
        for (int i = 0; i < m_win.size(); i++) begin
            blocked = 1'b0;
            for (int j = 0; j < i; j++) begin
                if (same_addr(m_win[j], m_win[i])) blocked = 1'b1;   // older same address
            end
            if (pick < 0 && !blocked && open_hit(m_win[i])) pick = i;
        end
        return (pick < 0) ? 0 : pick;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare, then step the model through the coming edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk_i) begin : model_step
        logic [ENT_W-1:0] sel;
        int               idx;
        logic             push;
        logic             pick;
        logic             take;
        if (reset_i) begin
            m_fifo.delete();
            m_win.delete();
            m_out          = '0;
            m_out_vld      = 1'b0;
            m_out_hit      = 1'b0;
            m_row_vld      = '0;            // all banks closed
            idle_o         = 1'b1;
            accepted_o     = 0;
            issued_o       = 0;
            errors_o       = 0;
            tests_passed_o = 0;
            tests_failed_o = 0;
            err_mark       = 0;
        end else begin
            if (req_grant_i !== (m_fifo.size() < FIFO_DEPTH)) begin
                $display("Fail at time %0t: req_grant_o expected %0b, got %0b",
                         $time, m_fifo.size() < FIFO_DEPTH, req_grant_i);
                errors_o++;
            end
            if (issue_valid_i === 1'b1 && !m_out_vld) begin
                $display("at time %0t the DUT issued a request the model does not hold", $time);
                errors_o++;
            end else if (issue_valid_i !== 1'b1 && m_out_vld) begin
                $display("at time %0t the DUT is missing an issue of request %h",
                         $time, m_out[req_fmt_pkg::REQ_BITS-1:0]);
                errors_o++;
            end else if (m_out_vld) begin
                if (issue_data_i !== m_out[req_fmt_pkg::REQ_BITS-1:0]) begin
                    $display("Fail at time %0t: issue_data_o expected %h, got %h",
                             $time, m_out[req_fmt_pkg::REQ_BITS-1:0], issue_data_i);
                    errors_o++;
                end
                if (issue_row_hit_i !== m_out_hit) begin
                    $display("Fail at time %0t: issue_row_hit_o expected %0b, got %0b",
                             $time, m_out_hit, issue_row_hit_i);
                    errors_o++;
                end
                if (issue_ready_i && m_out[ENT_W-1 -: 2] != 2'd2 &&
                    issue_row_hit_i !== m_out[ENT_W-2]) begin         // table value
                    $display("Fail at time %0t: table row hit %0b, got %0b for %h",
                             $time, m_out[ENT_W-2], issue_row_hit_i, issue_data_i);
                    errors_o++;
                end
            end
            if (issue_valid_i === 1'b1 && issue_ready_i === 1'b1) issued_o++;

            push = req_valid_i && (m_fifo.size() < FIFO_DEPTH);
            pick = (m_win.size() > 0) && (!m_out_vld || issue_ready_i);
            take = (m_fifo.size() > 0) && ((m_win.size() < WINDOW_DEPTH) || pick);
            if (pick) begin
                idx       = choose_entry();
                sel       = m_win[idx];
                m_out     = sel;
                m_out_hit = open_hit(sel);      // before the row update
                m_out_vld = 1'b1;
                m_win.delete(idx);
                m_row[bank_of(sel)]     = row_of(sel);
                m_row_vld[bank_of(sel)] = 1'b1;
            end else if (issue_ready_i) begin
                m_out_vld = 1'b0;
            end
            if (take) m_win.push_back(m_fifo.pop_front());   // youngest in window
            if (push) begin
                m_fifo.push_back({exp_hit_i, req_data_i});
                accepted_o++;
            end
            idle_o = (m_fifo.size() == 0) && (m_win.size() == 0) && !m_out_vld;

            if (test_done_i) begin
                if (errors_o == err_mark) begin
                    tests_passed_o++;
                    $display("test %0d passed, %0d issued so far", test_id_i, issued_o);
                end else begin
                    tests_failed_o++;
                    $display("test %0d failed with %0d errors", test_id_i, errors_o - err_mark);
                end
                err_mark = errors_o;
            end
        end
    end

endmodule

//--- bank_sched_tb.sv
module bank_sched_tb;

    localparam int FIFO_DEPTH   = 4;
    localparam int WINDOW_DEPTH = 4;
    localparam int N_ROWS       = 32;
    localparam int CYCLE_LIMIT  = 20 * N_ROWS + 100;

    localparam int   M_HIGH = 0;    // ready always high
    localparam int   M_HOLD = 1;    // ready low until the fifo fills
    localparam int   M_RAND = 2;    // ready from $random
    localparam int   ANY    = 2;    // row hit not fixed by the table
    localparam logic RD     = req_fmt_pkg::REQ_READ;
    localparam logic WR     = req_fmt_pkg::REQ_WRITE;

    logic                             clk;
    logic                             rst;
    logic                             req_valid;
    logic [req_fmt_pkg::REQ_BITS-1:0] req_data;
    logic                             req_grant;
    logic                             issue_ready;
    logic                             issue_valid;
    logic [req_fmt_pkg::REQ_BITS-1:0] issue_data;
    logic                             issue_hit;
    logic [1:0]                       exp_hit;
    logic                             test_done;
    int                               test_id;
    logic                             idle;
    int                               accepted;
    int                               issued;
    int                               errors;
    int                               tests_passed;
    int                               tests_failed;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    int          tab_test [N_ROWS];
    int          tab_bank [N_ROWS];
    int          tab_row  [N_ROWS];
    int          tab_col  [N_ROWS];
    logic        tab_typ  [N_ROWS];
    logic [15:0] tab_data [N_ROWS];
    int          tab_mode [N_ROWS];
    int          tab_exp  [N_ROWS];   // expected row hit
    int          n_fill;

    int          cur_mode;
    logic        hold_released;
    int          seed;
    logic [31:0] rnd;
    int          cycle_cnt;
    logic        run_ok;

    tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(3)) clk_gen (.clk_o(clk), .reset_o(rst));

    bank_sched_top #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .WINDOW_DEPTH (WINDOW_DEPTH)
    ) dut0 (
        .clk             (clk),
        .reset_i         (rst),
        .req_valid_i     (req_valid),
        .req_data_i      (req_data),
        .req_grant_o     (req_grant),
        .issue_ready_i   (issue_ready),
        .issue_valid_o   (issue_valid),
        .issue_data_o    (issue_data),
        .issue_row_hit_o (issue_hit)
    );

    bank_sched_checker #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .WINDOW_DEPTH (WINDOW_DEPTH)
    ) chk (
        .clk_i (clk), .reset_i (rst), .req_valid_i (req_valid), .req_data_i (req_data),
        .exp_hit_i (exp_hit), .req_grant_i (req_grant), .issue_ready_i (issue_ready),
        .issue_valid_i (issue_valid), .issue_data_i (issue_data), .issue_row_hit_i (issue_hit),
        .test_done_i (test_done), .test_id_i (test_id), .idle_o (idle),
        .accepted_o (accepted), .issued_o (issued), .errors_o (errors),
        .tests_passed_o (tests_passed), .tests_failed_o (tests_failed)
    );

    task automatic add_row(input int t, input int b, input int r, input int c, input logic ty,
                           input logic [15:0] d, input int m, input int e);
        tab_test[n_fill] = t;
        tab_bank[n_fill] = b;
        tab_row[n_fill]  = r;
        tab_col[n_fill]  = c;
        tab_typ[n_fill]  = ty;
        tab_data[n_fill] = d;
        tab_mode[n_fill] = m;
        tab_exp[n_fill]  = e;
        n_fill++;
    endtask

    task automatic fill_table();
        add_row(1, 0, 10, 1, WR, 16'h1001, M_HIGH, 0);     // first touch of each bank
        add_row(1, 1, 20, 2, WR, 16'h1002, M_HIGH, 0);
        add_row(1, 2, 30, 3, RD, 16'h1003, M_HIGH, 0);
        add_row(1, 3, 40, 4, RD, 16'h1004, M_HIGH, 0);
        add_row(1, 0, 10, 5, RD, 16'h1005, M_HIGH, 1);     // same row again
        add_row(1, 1, 21, 0, WR, 16'h1006, M_HIGH, 0);
        add_row(2, 3, 41, 0, RD, 16'h2001, M_HOLD, 0);     // parks in the output register
        add_row(2, 0, 12, 0, WR, 16'h2002, M_HOLD, 0);     // old miss, waits
        add_row(2, 1, 21, 1, RD, 16'h2003, M_HOLD, 1);
        add_row(2, 0, 10, 2, WR, 16'h2004, M_HOLD, 1);
        add_row(2, 2, 33, 0, RD, 16'h2005, M_HOLD, 0);
        add_row(2, 2, 30, 3, WR, 16'h2006, M_HOLD, 1);
        add_row(2, 3, 41, 2, RD, 16'h2007, M_HOLD, 1);
        add_row(2, 0, 12, 4, RD, 16'h2008, M_HOLD, 1);
        add_row(2, 1, 22, 0, WR, 16'h2009, M_HOLD, 0);
        add_row(3, 3, 40, 0, WR, 16'h3001, M_HOLD, 0);
        add_row(3, 0, 13, 0, RD, 16'h3002, M_HOLD, 0);
        add_row(3, 1, 22, 5, WR, 16'h3003, M_HOLD, 1);     // write then read, same address
        add_row(3, 1, 22, 5, RD, 16'h3004, M_HOLD, 1);
        add_row(3, 2, 33, 1, WR, 16'h3005, M_HOLD, 1);
        add_row(3, 2, 33, 1, RD, 16'h3006, M_HOLD, 1);
        add_row(3, 3, 40, 0, RD, 16'h3007, M_HOLD, 1);
        add_row(3, 0, 13, 1, WR, 16'h3008, M_HOLD, 1);
        add_row(3, 1, 23, 0, RD, 16'h3009, M_HOLD, 0);
        add_row(4, 0, 13, 2, RD, 16'h4001, M_RAND, ANY);
        add_row(4, 0, 14, 0, WR, 16'h4002, M_RAND, ANY);
        add_row(4, 1, 23, 1, RD, 16'h4003, M_RAND, ANY);
        add_row(4, 1, 23, 1, WR, 16'h4004, M_RAND, ANY);
        add_row(4, 2, 34, 0, RD, 16'h4005, M_RAND, ANY);
        add_row(4, 3, 40, 3, WR, 16'h4006, M_RAND, ANY);
        add_row(4, 0, 13, 2, WR, 16'h4007, M_RAND, ANY);
        add_row(4, 2, 33, 5, RD, 16'h4008, M_RAND, ANY);
    endtask

    // word layout top down is bank, row, column, type, data
    function automatic logic [req_fmt_pkg::REQ_BITS-1:0] make_req(input int i);
        logic [req_fmt_pkg::REQ_BITS-1:0] w;
        w = '0;
        w[req_fmt_pkg::BANK_POS +: dram_geom_pkg::BANK_BITS] = tab_bank[i];
        w[req_fmt_pkg::ROW_POS +: dram_geom_pkg::ROW_BITS]   = tab_row[i];
        w[req_fmt_pkg::COL_POS +: dram_geom_pkg::COL_BITS]   = tab_col[i];
        w[req_fmt_pkg::TYPE_POS]                             = tab_typ[i];
        w[req_fmt_pkg::DATA_POS +: req_fmt_pkg::DATA_BITS]   = tab_data[i];
        return w;
    endfunction

    task automatic update_ready();
        case (cur_mode)
            M_HIGH: issue_ready = 1'b1;
            M_HOLD: begin
                if (!req_grant) hold_released = 1'b1;   // fifo full so it may drain
                issue_ready = hold_released;
            end
            default: begin
                rnd         = $random(seed);
                issue_ready = rnd[0];
            end
        endcase
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        update_ready();
    endtask

    task automatic apply_row(input int i);
        req_valid = 1'b1;
        req_data  = make_req(i);
        exp_hit   = 2'(tab_exp[i]);
        while (!req_grant) next_cycle();    // grant holds until the next edge
        next_cycle();                       // accepted on this edge
    endtask

    task automatic finish_test(input int t);
        req_valid     = 1'b0;
        hold_released = 1'b1;               // no hold past the last row
        while (!idle) next_cycle();
        test_id   = t;
        test_done = 1'b1;
        next_cycle();
        test_done = 1'b0;
    endtask

    initial begin
        req_valid     = 1'b0;
        req_data      = '0;
        issue_ready   = 1'b0;
        exp_hit       = 2'd0;
        test_done     = 1'b0;
        test_id       = 0;
        cur_mode      = M_HIGH;
        hold_released = 1'b0;
        seed          = 64064;
        n_fill        = 0;
        cycle_cnt     = 0;
        run_ok        = 1'b1;
        fill_table();
        next_cycle();
        while (rst) next_cycle();
        for (int i = 0; i < N_ROWS; i++) begin
            if (i > 0 && tab_test[i] != tab_test[i-1]) finish_test(tab_test[i-1]);
            if (i == 0 || tab_test[i] != tab_test[i-1]) begin
                cur_mode      = tab_mode[i];        // ready mode of the new test
                hold_released = 1'b0;
                update_ready();
            end
            apply_row(i);
        end
        finish_test(tab_test[N_ROWS-1]);
        if (accepted != N_ROWS || issued != N_ROWS) begin
            $display("%0d requests accepted and %0d issued, %0d of each expected",
                     accepted, issued, N_ROWS);
            run_ok = 1'b0;
        end
        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (run_ok && errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // limit from the table length
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout, run still busy after %0d cycles", cycle_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule

//--- files.f
dram_geom_pkg.sv
req_fmt_pkg.sv
generic_fifo.sv
open_row_table.sv
bank_scheduler.sv
bank_sched_top.sv
tb_clock_gen.sv
bank_sched_checker.sv
bank_sched_tb.sv
